// File: common/isa_pkg.sv
package isa_pkg;

    ////////////////////////////////////////////////////////////
    // instruction word and class
    ////////////////////////////////////////////////////////////

    typedef logic [15:0] instr_word_t;     // bits [15:14] carry the class

    typedef enum logic [1:0] {
        class_alu    = 2'b00,
        class_ld_st  = 2'b01,
        class_branch = 2'b10               // issues to the alu station
    } op_class_t;

    typedef struct packed {
        logic        valid;
        op_class_t   op_class;
        instr_word_t word;
    } decoded_instr_t;

endpackage

// File: common/pipe_pkg.sv
package pipe_pkg;

    ////////////////////////////////////////////////////////////
    // occupancy of the back end queues
    ////////////////////////////////////////////////////////////

    typedef logic [3:0] occupancy_t;       // up to 15 entries

    typedef struct packed {
        logic rs_alu_full;
        logic rs_ld_st_full;
        logic rob_full;
        logic lb_full;
    } resource_status_t;

    ////////////////////////////////////////////////////////////
    // execute result registers
    ////////////////////////////////////////////////////////////

    // one bit per result register waiting for the common data bus
    typedef struct packed {
        logic alu_wr_valid;
        logic lb_wr_valid;
        logic acu_wr_valid;
    } slot_status_t;

    ////////////////////////////////////////////////////////////
    // dispatch pulses out of the issue stage
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic rs_alu_enable;
        logic rs_ld_st_enable;
        logic rob_enable;
    } dispatch_t;

endpackage

// File: logic/issue_latch.sv
module issue_latch import isa_pkg::*; (
    input  logic           clock,
    input  logic           reset,
    input  logic           instr_valid,
    input  instr_word_t    instr_word,
    input  logic           load_enable,
    input  logic           flush,
    output decoded_instr_t issue
);

    function automatic op_class_t decode_class(input instr_word_t word);
        op_class_t op_class;
        case (word[15:14])
            2'b01:   op_class = class_ld_st;
            2'b10:   op_class = class_branch;
            default: op_class = class_alu;  // 2'b11 is treated as alu
        endcase
        return op_class;
    endfunction

    ////////////////////////////////////////////////////////////
    // IF/IS register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            issue.valid <= 1'b0;
        end else if (flush) begin
            issue.valid <= 1'b0;              // flush beats load
        end else if (load_enable) begin
            issue.valid <= instr_valid;       // bubble when nothing arrives
        end
    end

    always_ff @(posedge clock) begin
        if (load_enable && !flush) begin
            issue.op_class <= decode_class(instr_word);
            issue.word     <= instr_word;
        end
    end

endmodule

// File: hazard/hazard_unit.sv
module hazard_unit import isa_pkg::*, pipe_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  decoded_instr_t   issue,
    input  resource_status_t resources,
    input  slot_status_t     slots,
    input  logic             alu_wr_written,
    input  logic             lb_wr_written,
    input  logic             acu_wr_written,
    input  logic             commit_wr_mem,
    input  logic             lb_read_mem,
    input  logic             dmem_wait,
    input  logic             acu_wr_mem,
    input  logic             acu_rd_mem,
    input  logic             alu_branch,
    input  logic             branch_misprediction,
    output dispatch_t        dispatch,
    output logic             if_enable,
    output logic             if_is_enable,
    output logic             if_is_flush,
    output logic             if_mem_hazard,
    output logic             rs_ld_exec_stall,
    output logic             rs_alu_exec_stall,
    output logic             lb_exec_stall
);

    logic is_ld_st;
    logic is_branch;
    logic is_stall;
    logic is_enable;
    logic branch_in_exec;
    logic alu_wr_enable;
    logic lb_wr_enable;
    logic acu_wr_enable;

    assign is_ld_st  = (issue.op_class == class_ld_st);
    assign is_branch = (issue.op_class == class_branch);

    ////////////////////////////////////////////////////////////
    // issue and fetch control
    ////////////////////////////////////////////////////////////

    assign is_stall = resources.rob_full
        | (is_ld_st & resources.rs_ld_st_full)
        | (~is_ld_st & resources.rs_alu_full)
        | branch_in_exec;

    assign is_enable = issue.valid & ~is_stall & ~branch_misprediction;

    assign dispatch.rs_alu_enable   = is_enable & ~is_ld_st;   // branches too
    assign dispatch.rs_ld_st_enable = is_enable & is_ld_st;
    assign dispatch.rob_enable      = is_enable;

    assign if_mem_hazard = commit_wr_mem | (lb_read_mem & ~dmem_wait);

    assign if_enable    = ~(if_mem_hazard | is_stall);
    assign if_is_enable = ~is_stall;
    assign if_is_flush  = branch_misprediction | (if_mem_hazard & ~is_stall);

    ////////////////////////////////////////////////////////////
    // execute stalls from the result registers
    ////////////////////////////////////////////////////////////

    assign alu_wr_enable = ~slots.alu_wr_valid | alu_wr_written;
    assign lb_wr_enable  = ~slots.lb_wr_valid  | lb_wr_written;
    assign acu_wr_enable = ~slots.acu_wr_valid | acu_wr_written;

    assign rs_alu_exec_stall = ~alu_wr_enable;
    assign rs_ld_exec_stall  = (acu_wr_mem & ~acu_wr_enable)
        | (acu_rd_mem & resources.lb_full);
    assign lb_exec_stall     = commit_wr_mem | ~lb_wr_enable | dmem_wait;

    // one branch in flight at a time, released once the alu resolves it
    always_ff @(posedge clock) begin
        if (reset) begin
            branch_in_exec <= 1'b0;
        end else if (is_branch && dispatch.rs_alu_enable) begin
            branch_in_exec <= 1'b1;
        end else if (alu_branch && !rs_alu_exec_stall) begin
            branch_in_exec <= 1'b0;           // a stalled alu holds the branch
        end
    end

endmodule

// File: logic/resource_tracker.sv
module resource_tracker import pipe_pkg::*; #(
    parameter int RS_ALU_DEPTH   = 4,
    parameter int RS_LD_ST_DEPTH = 4,
    parameter int ROB_DEPTH      = 4,
    parameter int LB_DEPTH       = 4
) (
    input  logic             clock,
    input  logic             reset,
    input  dispatch_t        dispatch,
    input  logic             alu_issue_done,
    input  logic             ld_st_issue_done,
    input  logic             rob_retire,
    input  logic             lb_release,
    output resource_status_t resources
);

    localparam occupancy_t RS_ALU_MAX   = occupancy_t'(RS_ALU_DEPTH);
    localparam occupancy_t RS_LD_ST_MAX = occupancy_t'(RS_LD_ST_DEPTH);
    localparam occupancy_t ROB_MAX      = occupancy_t'(ROB_DEPTH);
    localparam occupancy_t LB_MAX       = occupancy_t'(LB_DEPTH);

    occupancy_t rs_alu_count;
    occupancy_t rs_ld_st_count;
    occupancy_t rob_count;
    occupancy_t lb_count;

    // saturates at depth and at zero
    function automatic occupancy_t step(input occupancy_t count, input logic inc,
                                        input logic dec, input occupancy_t depth);
        occupancy_t next;
        next = count;
        if (inc && !dec && count != depth) begin
            next = count + 1'b1;
        end else if (dec && !inc && count != '0) begin
            next = count - 1'b1;
        end
        return next;
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            rs_alu_count   <= '0;
            rs_ld_st_count <= '0;
            rob_count      <= '0;
            lb_count       <= '0;
        end else begin
            rs_alu_count   <= step(rs_alu_count, dispatch.rs_alu_enable,
                                   alu_issue_done, RS_ALU_MAX);
            rs_ld_st_count <= step(rs_ld_st_count, dispatch.rs_ld_st_enable,
                                   ld_st_issue_done, RS_LD_ST_MAX);
            rob_count      <= step(rob_count, dispatch.rob_enable, rob_retire, ROB_MAX);
            lb_count       <= step(lb_count, dispatch.rs_ld_st_enable,
                                   lb_release, LB_MAX);   // every ld/st takes an lb entry
        end
    end

    assign resources.rs_alu_full   = (rs_alu_count == RS_ALU_MAX);
    assign resources.rs_ld_st_full = (rs_ld_st_count == RS_LD_ST_MAX);
    assign resources.rob_full      = (rob_count == ROB_MAX);
    assign resources.lb_full       = (lb_count == LB_MAX);

endmodule

// File: logic/result_slots.sv
module result_slots import pipe_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  logic         alu_produce,
    input  logic         lb_produce,
    input  logic         acu_produce,
    input  logic         alu_wr_written,
    input  logic         lb_wr_written,
    input  logic         acu_wr_written,
    output slot_status_t slots
);

    // a full slot only empties on its bus write, an empty one fills on produce
    function automatic logic slot_next(input logic valid, input logic produce,
                                       input logic written);
        logic next;
        if (valid) begin
            next = ~written;
        end else begin
            next = produce;
        end
        return next;
    endfunction

    ////////////////////////////////////////////////////////////
    // result register valid bits
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            slots <= '0;
        end else begin
            slots.alu_wr_valid <= slot_next(slots.alu_wr_valid, alu_produce,
                                            alu_wr_written);
            slots.lb_wr_valid  <= slot_next(slots.lb_wr_valid, lb_produce,
                                            lb_wr_written);
            slots.acu_wr_valid <= slot_next(slots.acu_wr_valid, acu_produce,
                                            acu_wr_written);
        end
    end

endmodule

// File: logic/dispatch_core.sv
module dispatch_core import isa_pkg::*, pipe_pkg::*; #(
    parameter int RS_ALU_DEPTH   = 4,
    parameter int RS_LD_ST_DEPTH = 4,
    parameter int ROB_DEPTH      = 4,
    parameter int LB_DEPTH       = 4
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        instr_valid,
    input  instr_word_t instr_word,
    input  logic        alu_issue_done,
    input  logic        ld_st_issue_done,
    input  logic        rob_retire,
    input  logic        lb_release,
    input  logic        alu_produce,
    input  logic        lb_produce,
    input  logic        acu_produce,
    input  logic        alu_wr_written,
    input  logic        lb_wr_written,
    input  logic        acu_wr_written,
    input  logic        commit_wr_mem,
    input  logic        lb_read_mem,
    input  logic        dmem_wait,
    input  logic        acu_wr_mem,
    input  logic        acu_rd_mem,
    input  logic        alu_branch,
    input  logic        branch_misprediction,
    output logic        instr_ready,
    output dispatch_t   dispatch,
    output logic        if_is_flush,
    output logic        if_mem_hazard,
    output logic        rs_ld_exec_stall,
    output logic        rs_alu_exec_stall,
    output logic        lb_exec_stall
);

    decoded_instr_t   issue;
    resource_status_t resources;
    slot_status_t     slots;
    logic             if_is_enable;

    issue_latch u_issue_latch (
        .clock       (clock),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .load_enable (if_is_enable),
        .flush       (if_is_flush),
        .issue       (issue)
    );

    hazard_unit u_hazard_unit (
        .clock                (clock),
        .reset                (reset),
        .issue                (issue),
        .resources            (resources),
        .slots                (slots),
        .alu_wr_written       (alu_wr_written),
        .lb_wr_written        (lb_wr_written),
        .acu_wr_written       (acu_wr_written),
        .commit_wr_mem        (commit_wr_mem),
        .lb_read_mem          (lb_read_mem),
        .dmem_wait            (dmem_wait),
        .acu_wr_mem           (acu_wr_mem),
        .acu_rd_mem           (acu_rd_mem),
        .alu_branch           (alu_branch),
        .branch_misprediction (branch_misprediction),
        .dispatch             (dispatch),
        .if_enable            (instr_ready),        // fetch accepts while enabled
        .if_is_enable         (if_is_enable),
        .if_is_flush          (if_is_flush),
        .if_mem_hazard        (if_mem_hazard),
        .rs_ld_exec_stall     (rs_ld_exec_stall),
        .rs_alu_exec_stall    (rs_alu_exec_stall),
        .lb_exec_stall        (lb_exec_stall)
    );

    resource_tracker #(
        .RS_ALU_DEPTH   (RS_ALU_DEPTH),
        .RS_LD_ST_DEPTH (RS_LD_ST_DEPTH),
        .ROB_DEPTH      (ROB_DEPTH),
        .LB_DEPTH       (LB_DEPTH)
    ) u_resource_tracker (
        .clock            (clock),
        .reset            (reset),
        .dispatch         (dispatch),
        .alu_issue_done   (alu_issue_done),
        .ld_st_issue_done (ld_st_issue_done),
        .rob_retire       (rob_retire),
        .lb_release       (lb_release),
        .resources        (resources)
    );

    result_slots u_result_slots (
        .clock          (clock),
        .reset          (reset),
        .alu_produce    (alu_produce),
        .lb_produce     (lb_produce),
        .acu_produce    (acu_produce),
        .alu_wr_written (alu_wr_written),
        .lb_wr_written  (lb_wr_written),
        .acu_wr_written (acu_wr_written),
        .slots          (slots)
    );

endmodule

// File: testbench/clock_gen.sv
module clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;         // period 100
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

// File: testbench/dispatch_core_tb.sv
module dispatch_core_tb import isa_pkg::*, pipe_pkg::*; ();

    localparam int ROB_DEPTH = 4;
    localparam int LB_DEPTH  = 4;

    localparam instr_word_t W_ALU  = 16'h0123;    // class bits 00
    localparam instr_word_t W_LDST = 16'h4567;    // class bits 01
    localparam instr_word_t W_BR   = 16'h8009;    // class bits 10

    // one bit per external control pulse
    localparam logic [16:0] ALU_DONE  = 17'h00001;
    localparam logic [16:0] LDST_DONE = 17'h00002;
    localparam logic [16:0] RETIRE    = 17'h00004;
    localparam logic [16:0] LB_REL    = 17'h00008;
    localparam logic [16:0] ALU_PROD  = 17'h00010;
    localparam logic [16:0] LB_PROD   = 17'h00020;
    localparam logic [16:0] ACU_PROD  = 17'h00040;
    localparam logic [16:0] ALU_WR    = 17'h00080;
    localparam logic [16:0] LB_WR     = 17'h00100;
    localparam logic [16:0] ACU_WR    = 17'h00200;
    localparam logic [16:0] COMMIT    = 17'h00400;
    localparam logic [16:0] LB_READ   = 17'h00800;
    localparam logic [16:0] DMEM_WAIT = 17'h01000;
    localparam logic [16:0] ACU_WMEM  = 17'h02000;
    localparam logic [16:0] ACU_RMEM  = 17'h04000;
    localparam logic [16:0] ALU_BR    = 17'h08000;
    localparam logic [16:0] MISPRED   = 17'h10000;

    // expected outputs in the order of the observed vector below
    localparam logic [8:0] E_READY    = 9'h100;
    localparam logic [8:0] D_ALU      = 9'h0a0;   // alu station and rob
    localparam logic [8:0] D_LDST     = 9'h060;   // ld/st station and rob
    localparam logic [8:0] E_FLUSH    = 9'h010;
    localparam logic [8:0] E_MEMHZ    = 9'h008;
    localparam logic [8:0] E_LDSTALL  = 9'h004;
    localparam logic [8:0] E_ALUSTALL = 9'h002;
    localparam logic [8:0] E_LBSTALL  = 9'h001;

    typedef struct packed {
        int          test;
        logic        valid;
        instr_word_t word;
        logic [16:0] ctl;
        logic [8:0]  exp_out;
    } row_t;

    logic        clock;
    logic        reset;
    logic        instr_valid;
    instr_word_t instr_word;
    logic [16:0] ctl;
    logic        instr_ready;
    dispatch_t   dispatch;
    logic        if_is_flush;
    logic        if_mem_hazard;
    logic        rs_ld_exec_stall;
    logic        rs_alu_exec_stall;
    logic        lb_exec_stall;
    logic [8:0]  observed;
    row_t        rows[$];
    int          errors;
    int          test_errors;
    int          tests;
    int          failed_tests;

    assign observed = {instr_ready, dispatch, if_is_flush, if_mem_hazard,
                       rs_ld_exec_stall, rs_alu_exec_stall, lb_exec_stall};

    clock_gen u_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    dispatch_core #(
        .RS_ALU_DEPTH   (4),
        .RS_LD_ST_DEPTH (4),
        .ROB_DEPTH      (ROB_DEPTH),
        .LB_DEPTH       (LB_DEPTH)
    ) u_dispatch_core (
        .clock                (clock),
        .reset                (reset),
        .instr_valid          (instr_valid),
        .instr_word           (instr_word),
        .alu_issue_done       (ctl[0]),
        .ld_st_issue_done     (ctl[1]),
        .rob_retire           (ctl[2]),
        .lb_release           (ctl[3]),
        .alu_produce          (ctl[4]),
        .lb_produce           (ctl[5]),
        .acu_produce          (ctl[6]),
        .alu_wr_written       (ctl[7]),
        .lb_wr_written        (ctl[8]),
        .acu_wr_written       (ctl[9]),
        .commit_wr_mem        (ctl[10]),
        .lb_read_mem          (ctl[11]),
        .dmem_wait            (ctl[12]),
        .acu_wr_mem           (ctl[13]),
        .acu_rd_mem           (ctl[14]),
        .alu_branch           (ctl[15]),
        .branch_misprediction (ctl[16]),
        .instr_ready          (instr_ready),
        .dispatch             (dispatch),
        .if_is_flush          (if_is_flush),
        .if_mem_hazard        (if_mem_hazard),
        .rs_ld_exec_stall     (rs_ld_exec_stall),
        .rs_alu_exec_stall    (rs_alu_exec_stall),
        .lb_exec_stall        (lb_exec_stall)
    );

    task automatic add_row(input int test, input logic valid, input instr_word_t word,
                           input logic [16:0] row_ctl, input logic [8:0] exp_out);
        rows.push_back(row_t'({test, valid, word, row_ctl, exp_out}));
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus table, one row per clock cycle
    ////////////////////////////////////////////////////////////

    task automatic build_table();
        add_row(1, 1'b1, W_ALU, '0, E_READY);
        add_row(1, 1'b1, W_LDST, '0, E_READY | D_ALU);   // dispatch one cycle after accept
        add_row(1, 1'b0, W_ALU, '0, E_READY | D_LDST);
        add_row(1, 1'b0, W_ALU, RETIRE | ALU_DONE, E_READY);
        add_row(1, 1'b0, W_ALU, RETIRE | LDST_DONE | LB_REL, E_READY);
        add_row(2, 1'b1, W_ALU, '0, E_READY);
        for (int k = 1; k <= ROB_DEPTH; k++) begin
            add_row(2, 1'b1, W_ALU, ALU_DONE, E_READY | D_ALU);
        end
        add_row(2, 1'b0, W_ALU, '0, '0);                 // rob full so the instruction is held
        add_row(2, 1'b0, W_ALU, RETIRE, '0);
        add_row(2, 1'b0, W_ALU, ALU_DONE, E_READY | D_ALU);
        add_row(2, 1'b0, W_ALU, RETIRE, '0);
        for (int k = 1; k < ROB_DEPTH; k++) begin
            add_row(2, 1'b0, W_ALU, RETIRE, E_READY);
        end
        add_row(3, 1'b1, W_BR, '0, E_READY);
        add_row(3, 1'b1, W_ALU, ALU_DONE, E_READY | D_ALU);
        add_row(3, 1'b0, W_ALU, RETIRE | ALU_PROD, '0);  // branch in execute
        add_row(3, 1'b0, W_ALU, ALU_BR, E_ALUSTALL);      // slot full so the branch stays
        add_row(3, 1'b0, W_ALU, ALU_BR | ALU_WR, '0);
        add_row(3, 1'b0, W_ALU, ALU_DONE, E_READY | D_ALU);
        add_row(3, 1'b0, W_ALU, RETIRE, E_READY);
        add_row(4, 1'b1, W_ALU, COMMIT, E_FLUSH | E_MEMHZ | E_LBSTALL);
        add_row(4, 1'b0, W_ALU, '0, E_READY);
        add_row(4, 1'b0, W_ALU, LB_READ, E_FLUSH | E_MEMHZ);
        add_row(4, 1'b1, W_ALU, '0, E_READY);
        add_row(4, 1'b0, W_ALU, MISPRED, E_READY | E_FLUSH);
        add_row(4, 1'b0, W_ALU, '0, E_READY);
        add_row(5, 1'b0, W_ALU, ALU_PROD, E_READY);
        add_row(5, 1'b0, W_ALU, '0, E_READY | E_ALUSTALL);
        add_row(5, 1'b0, W_ALU, ALU_WR, E_READY);
        add_row(5, 1'b0, W_ALU, LB_READ | DMEM_WAIT, E_READY | E_LBSTALL);
        add_row(5, 1'b1, W_LDST, '0, E_READY);
        for (int k = 1; k <= LB_DEPTH; k++) begin
            add_row(5, k < LB_DEPTH, W_LDST, LDST_DONE | RETIRE, E_READY | D_LDST);
        end
        add_row(5, 1'b0, W_LDST, ACU_RMEM, E_READY | E_LDSTALL);   // lb now full
        add_row(5, 1'b0, W_LDST, LB_PROD | ACU_PROD, E_READY);
        add_row(5, 1'b0, W_LDST, ACU_WMEM, E_READY | E_LDSTALL | E_LBSTALL);
        add_row(5, 1'b0, W_LDST, ACU_WMEM | ACU_WR | LB_WR, E_READY);
    endtask

    task automatic report_test(input int test);
        tests++;
        if (test_errors == 0) begin
            $display("test %0d done, no errors", test);
        end else begin
            $display("test %0d done, %0d errors", test, test_errors);
            failed_tests++;
        end
        test_errors = 0;
    endtask

    initial begin
        instr_valid <= 1'b0;
        instr_word  <= '0;
        ctl         <= '0;
        build_table();
        wait (reset === 1'b1);
        wait (reset === 1'b0);
        @(negedge clock);
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clock);
            instr_valid <= rows[i].valid;
            instr_word  <= rows[i].word;
            ctl         <= rows[i].ctl;
            @(negedge clock);                          // outputs settled mid cycle
            if (observed !== rows[i].exp_out) begin
                $display("MISMATCH at %0t: test %0d row %0d expected %b got %b",
                         $time, rows[i].test, i, rows[i].exp_out, observed);
                errors++;
                test_errors++;
            end
            if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
                report_test(rows[i].test);
            end
        end
        $display("%0d tests, %0d failed, %0d mismatches", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #1;
        #((rows.size() + 20) * 100);
        $display("timeout: the stimulus table did not finish in time");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: list.f
common/isa_pkg.sv
common/pipe_pkg.sv
logic/issue_latch.sv
hazard/hazard_unit.sv
logic/resource_tracker.sv
logic/result_slots.sv
logic/dispatch_core.sv
testbench/clock_gen.sv
testbench/dispatch_core_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module dispatch_core_tb -f list.f -o sim_dispatch_core \
    && ./obj_dir/sim_dispatch_core | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
